// ==== src.f ====
design/core_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/register_file.sv
design/alu_unit.sv
design/branch_unit.sv
design/core_control.sv
design/mini_core.sv
testbench/tb_mini_core_properties.sv
testbench/tb_mini_core.sv

// ==== testbench/tb_mini_core.sv ====
//////////////////////////////////////////////////////////////////////
// Mini core testbench
// Random program, variable latency memory, reference model and checks
//////////////////////////////////////////////////////////////////////

module tb_mini_core;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam word_t RESET_PC        = 32'h0000_0100;
    localparam int    RESET_CYCLES    = 8;
    localparam int    NUM_RETIRES     = 500;
    localparam int    MAX_LATENCY     = 4;
    localparam int    WATCHDOG_CYCLES = NUM_RETIRES * (MAX_LATENCY + 4) + RESET_CYCLES;

    logic    clk = 1'b0;
    logic    arst_n;
    logic    imem_valid;
    word_t   imem_rdata;
    logic    imem_req;
    word_t   imem_addr;
    logic    retire_valid;
    retire_t retire;

    word_t program_mem [256];
    word_t ref_regs [32];
    word_t ref_pc;
    word_t lfsr = 32'h3e67;

    mini_core #(
        .RESET_PC (RESET_PC)
    ) i_mini_core (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_valid   (imem_valid),
        .imem_rdata   (imem_rdata),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Stimulus generation

    // Galois LFSR stepped once per bit taken
    function automatic word_t lfsr_bits(input int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Byte offset to another word of the program
    function automatic logic [20:0] jump_offset(input int idx);
        int target;
        target = int'(lfsr_bits(8));
        if (target == idx) begin
            target = (idx + 1) % 256;
        end
        return 21'((target - idx) * 4);
    endfunction

    function automatic word_t make_instr(input int idx);
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [20:0] off;
        word_t       w;
        kind = 4'(lfsr_bits(4));
        rd   = 5'(lfsr_bits(5));
        rs1  = 5'(lfsr_bits(5));
        rs2  = 5'(lfsr_bits(5));
        f3   = 3'(lfsr_bits(3));
        if (kind <= 4) begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && lfsr_bits(1) == 1) ? 7'h20 : 7'h00;
            w  = {f7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind <= 9) begin
            imm = 12'(lfsr_bits(12));
            // Shift amounts carry funct7 in the upper immediate bits
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm[11:5] = (f3 == 3'd5 && imm[10]) ? 7'h20 : 7'h00;
            end
            w = {imm, rs1, f3, rd, 7'b0010011};
        end else if (kind <= 11) begin
            w = (lfsr_bits(20) << 12) | {20'h0, rd, 7'b0110111};
        end else if (kind <= 13) begin
            off = jump_offset(idx);
            f3  = {f3[1], 1'b0, f3[0]};
            w   = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
        end else if (kind == 14) begin
            off = jump_offset(idx);
            w   = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        end else begin
            // Load opcode left unimplemented by the core
            w = (lfsr_bits(25) << 7) | 32'h0000_0003;
        end
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic word_t alu_result_of(input logic [2:0] f3, input logic alt,
                                            input word_t a, input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic retire_t expected_retire();
        word_t      ins;
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       taken;
        retire_t    r;
        ins       = program_mem[ref_pc[9:2]];
        f3        = ins[14:12];
        f7        = ins[31:25];
        a         = ref_regs[ins[19:15]];
        b         = ref_regs[ins[24:20]];
        r         = '0;
        r.pc      = ref_pc;
        r.instr   = ins;
        r.rd      = ins[11:7];
        r.next_pc = ref_pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
                    r.rd_we   = 1'b1;
                    r.rd_data = alu_result_of(f3, f7[5], a, b);
                end
            end
            7'b0010011: begin
                if (!(f3 == 3'd1 && f7 != 7'h00) &&
                    !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
                    r.rd_we   = 1'b1;
                    r.rd_data = alu_result_of(f3, f3 == 3'd5 && f7[5], a,
                                              {{20{ins[31]}}, ins[31:20]});
                end
            end
            7'b0110111: begin
                r.rd_we   = 1'b1;
                r.rd_data = {ins[31:12], 12'h000};
            end
            7'b1100011: begin
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    r.next_pc = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                r.rd_we   = 1'b1;
                r.rd_data = ref_pc + 32'd4;
                r.next_pc = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
            end
            default: begin
            end
        endcase
        // x0 stays zero
        if (r.rd == 5'd0) begin
            r.rd_we = 1'b0;
        end
        if (r.rd_we) begin
            ref_regs[r.rd] = r.rd_data;
        end
        ref_pc = r.next_pc;
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        abort_run($sformatf("FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            report_mismatch(name, got, exp);
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        check_addr(got.pc, exp.pc, "retire.pc");
        check_addr(got.instr, exp.instr, "retire.instr");
        check_addr(word_t'(got.rd_we), word_t'(exp.rd_we), "retire.rd_we");
        check_addr(word_t'(got.rd), word_t'(exp.rd), "retire.rd");
        if (exp.rd_we) begin
            check_addr(got.rd_data, exp.rd_data, "retire.rd_data");
        end
        check_addr(got.next_pc, exp.next_pc, "retire.next_pc");
    endtask

    initial begin : reset_and_program
        int i;
        for (i = 0; i < 256; i++) begin
            program_mem[i] = make_instr(i);
        end
        arst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

    // Answers each request after 1 to MAX_LATENCY cycles
    initial begin : memory_model
        int    latency;
        word_t req_addr;
        imem_valid <= 1'b0;
        imem_rdata <= '0;
        forever begin
            @(posedge clk);
            imem_valid <= 1'b0;
            if (arst_n && imem_req) begin
                req_addr = imem_addr;
                latency  = 1 + int'(lfsr_bits(2));
                repeat (latency - 1) @(posedge clk);
                imem_valid <= 1'b1;
                imem_rdata <= program_mem[req_addr[9:2]];
            end
        end
    end

    initial begin : compare_retires
        retire_t    exp_retire;
        word_t      exp_addr;
        logic       req_pending;
        logic [1:0] valid_hist;
        int         retire_count;
        int         i;
        for (i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc       = RESET_PC;
        exp_addr     = RESET_PC;
        req_pending  = 1'b0;
        valid_hist   = 2'b00;
        retire_count = 0;
        while (retire_count < NUM_RETIRES) begin
            @(posedge clk);
            if (!arst_n && (imem_req || retire_valid)) begin
                abort_run("Request or retire pulse while reset is asserted");
            end
            if (imem_req && req_pending) begin
                abort_run("New instruction request while the previous one is outstanding");
            end
            if (retire_valid !== valid_hist[1]) begin
                abort_run("retire_valid did not follow imem_valid by two cycles");
            end
            valid_hist = {valid_hist[0], imem_valid};
            if (imem_valid) begin
                req_pending = 1'b0;
            end
            if (imem_req) begin
                check_addr(imem_addr, exp_addr, "imem_addr");
                req_pending = 1'b1;
            end
            if (retire_valid) begin
                exp_retire = expected_retire();
                check_retire(retire, exp_retire);
                exp_addr = exp_retire.next_pc;
                retire_count++;
            end
        end
        $display("All checks passed");
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the core did not retire enough instructions in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== testbench/tb_mini_core_properties.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch and retire timing assertions for the mini core
//////////////////////////////////////////////////////////////////////

module tb_mini_core_properties (
    input logic clk,
    input logic arst_n,
    input logic imem_req,
    input logic imem_valid,
    input logic retire_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // Request issued and answer not yet seen
    logic req_pending;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_pending <= 1'b0;
        end else if (imem_req) begin
            req_pending <= 1'b1;
        end else if (imem_valid) begin
            req_pending <= 1'b0;
        end
    end

    req_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req |=> !imem_req)
        else $error("imem_req held for more than one cycle");

    single_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        req_pending |-> !imem_req)
        else $error("imem_req issued before imem_valid of the previous request");

    retire_after_valid: assert property (@(posedge clk) disable iff (!arst_n)
        imem_valid |=> !retire_valid ##1 retire_valid)
        else $error("retire_valid not exactly two cycles after imem_valid");

endmodule

bind mini_core tb_mini_core_properties i_tb_mini_core_properties (
    .clk          (clk),
    .arst_n       (arst_n),
    .imem_req     (imem_req),
    .imem_valid   (imem_valid),
    .retire_valid (retire_valid)
);

// ==== design/mini_core.sv ====
//////////////////////////////////////////////////////////////////////
// Mini RV32I core top level
// Multicycle integer core with instruction memory and retire ports
//////////////////////////////////////////////////////////////////////

module mini_core #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              imem_valid,
    input  core_pkg::word_t   imem_rdata,
    output logic              imem_req,
    output core_pkg::word_t   imem_addr,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    // Control to datapath
    logic fetch_req;
    logic capture;
    logic decode_en;
    logic execute_en;

    word_t    pc;
    word_t    instr;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    word_t    next_pc;
    word_t    rd_data;
    logic     rf_we;

    assign rf_we = execute_en & dec.rd_we;

    core_control i_core_control (
        .clk          (clk),
        .arst_n       (arst_n),
        .imem_valid   (imem_valid),
        .pc           (pc),
        .instr        (instr),
        .dec          (dec),
        .rd_data      (rd_data),
        .next_pc      (next_pc),
        .fetch_req    (fetch_req),
        .capture      (capture),
        .decode_en    (decode_en),
        .execute_en   (execute_en),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) i_fetch_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch_req  (fetch_req),
        .capture    (capture),
        .execute_en (execute_en),
        .imem_rdata (imem_rdata),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .pc         (pc),
        .instr      (instr)
    );

    decode_unit i_decode_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .decode_en (decode_en),
        .instr     (instr),
        .dec       (dec)
    );

    register_file i_register_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .we       (rf_we),
        .rd       (dec.rd),
        .wdata    (rd_data),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu_unit i_alu_unit (
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (alu_result)
    );

    branch_unit i_branch_unit (
        .dec        (dec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .rd_data    (rd_data)
    );

endmodule

// ==== design/core_control.sv ====
//////////////////////////////////////////////////////////////////////
// Core control
// Sequences one instruction through fetch, decode and execute
//////////////////////////////////////////////////////////////////////

module core_control (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               imem_valid,
    input  core_pkg::word_t    pc,
    input  core_pkg::word_t    instr,
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    rd_data,
    input  core_pkg::word_t    next_pc,
    output logic               fetch_req,
    output logic               capture,
    output logic               decode_en,
    output logic               execute_en,
    output logic               retire_valid,
    output core_pkg::retire_t  retire
);
    import core_pkg::*;

    core_state_e state_q;
    core_state_e stage;
    core_state_e state_next;

    // The cycle in which the word arrives counts as the decode cycle
    assign stage = (state_q == ST_WAIT_MEM && imem_valid) ? ST_DECODE : state_q;

    always_comb begin
        case (stage)
            ST_FETCH:    state_next = ST_WAIT_MEM;
            ST_WAIT_MEM: state_next = ST_WAIT_MEM;
            ST_DECODE:   state_next = ST_EXECUTE;
            default:     state_next = ST_FETCH;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath enables
    assign fetch_req  = (stage == ST_FETCH);
    assign capture    = (stage == ST_DECODE);
    assign decode_en  = (stage == ST_DECODE);
    assign execute_en = (stage == ST_EXECUTE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= ST_FETCH;
            retire_valid <= 1'b0;
        end else begin
            state_q      <= state_next;
            retire_valid <= execute_en;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Retire record presented the cycle after execute
    always_ff @(posedge clk) begin
        if (execute_en) begin
            retire.pc      <= pc;
            retire.instr   <= instr;
            retire.rd      <= dec.rd;
            retire.rd_we   <= dec.rd_we;
            retire.rd_data <= rd_data;
            retire.next_pc <= next_pc;
        end
    end

endmodule

// ==== design/branch_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Branch unit
// Branch condition, next PC and writeback value selection
//////////////////////////////////////////////////////////////////////

module branch_unit (
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    pc,
    input  core_pkg::word_t    rs1_data,
    input  core_pkg::word_t    rs2_data,
    input  core_pkg::word_t    alu_result,
    output core_pkg::word_t    next_pc,
    output core_pkg::word_t    rd_data
);
    import core_pkg::*;

    word_t seq_pc;
    word_t target;
    logic  taken;

    assign seq_pc = pc + INSTR_BYTES;
    assign target = pc + dec.imm;

    // Branch condition with signed compares for BLT and BGE
    always_comb begin
        case (dec.br_op)
            BR_BEQ:  taken = (rs1_data == rs2_data);
            BR_BNE:  taken = (rs1_data != rs2_data);
            BR_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? target : seq_pc;

    // Link address for JAL
    assign rd_data = (dec.br_op == BR_JAL) ? seq_pc : alu_result;

endmodule

// ==== design/alu_unit.sv ====
//////////////////////////////////////////////////////////////////////
// ALU
// Add, subtract, logic, compare and shifts on register or immediate
//////////////////////////////////////////////////////////////////////

module alu_unit (
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    rs1_data,
    input  core_pkg::word_t    rs2_data,
    output core_pkg::word_t    result
);
    import core_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;

    // Second operand
    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD: begin
                result = rs1_data + op_b;
            end
            ALU_SUB: begin
                result = rs1_data - op_b;
            end
            ALU_AND: begin
                result = rs1_data & op_b;
            end
            ALU_OR: begin
                result = rs1_data | op_b;
            end
            ALU_XOR: begin
                result = rs1_data ^ op_b;
            end
            ALU_SLT: begin
                result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            end
            ALU_SLTU: begin
                result = {31'b0, rs1_data < op_b};
            end
            ALU_SLL: begin
                result = rs1_data << shamt;
            end
            ALU_SRL: begin
                result = rs1_data >> shamt;
            end
            ALU_SRA: begin
                result = word_t'($signed(rs1_data) >>> shamt);
            end
            // LUI
            default: begin
                result = op_b;
            end
        endcase
    end

endmodule

// ==== design/register_file.sv ====
//////////////////////////////////////////////////////////////////////
// Register file
// 32 general registers, two read ports and one write port
//////////////////////////////////////////////////////////////////////

module register_file (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               we,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t    wdata,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data
);
    import core_pkg::*;

    word_t regs [32];

    // Register zero is cleared by reset and never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Asynchronous reads
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// ==== design/decode_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Decode unit
// Field extraction, immediates and ALU / branch classification
//////////////////////////////////////////////////////////////////////

module decode_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               decode_en,
    input  core_pkg::word_t    instr,
    output core_pkg::decoded_t dec
);
    import core_pkg::*;

    opcode_e  opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t    imm_i;
    word_t    imm_u;
    word_t    imm_b;
    word_t    imm_j;
    alu_op_e  f3_op;
    decoded_t dec_next;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    //////////////////////////////////////////////////////////////////////
    // Immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 map shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            3'b000:  f3_op = ALU_ADD;
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b011:  f3_op = ALU_SLTU;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            default: f3_op = ALU_AND;
        endcase
    end

    always_comb begin
        dec_next     = '0;
        dec_next.rs1 = instr[19:15];
        dec_next.rs2 = instr[24:20];
        dec_next.rd  = instr[11:7];
        case (opcode)
            OPC_OP: begin
                dec_next.alu_op    = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : f3_op;
                dec_next.supported = (funct7 == 7'h00) ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
                dec_next.rd_we     = dec_next.supported;
            end
            OPC_OP_IMM: begin
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_i;
                dec_next.alu_op  = f3_op;
                // Shift immediates keep funct7 in the upper bits
                if (funct3 == 3'b001) begin
                    dec_next.supported = (funct7 == 7'h00);
                end else if (funct3 == 3'b101) begin
                    dec_next.supported = (funct7 == 7'h00) || (funct7 == 7'h20);
                end else begin
                    dec_next.supported = 1'b1;
                end
                dec_next.rd_we = dec_next.supported;
            end
            OPC_LUI: begin
                dec_next.use_imm   = 1'b1;
                dec_next.imm       = imm_u;
                dec_next.alu_op    = ALU_PASS_B;
                dec_next.supported = 1'b1;
                dec_next.rd_we     = 1'b1;
            end
            OPC_BRANCH: begin
                dec_next.imm = imm_b;
                case (funct3)
                    3'b000:  dec_next.br_op = BR_BEQ;
                    3'b001:  dec_next.br_op = BR_BNE;
                    3'b100:  dec_next.br_op = BR_BLT;
                    3'b101:  dec_next.br_op = BR_BGE;
                    default: dec_next.br_op = BR_NONE;
                endcase
                dec_next.supported = (dec_next.br_op != BR_NONE);
            end
            OPC_JAL: begin
                dec_next.imm       = imm_j;
                dec_next.br_op     = BR_JAL;
                dec_next.supported = 1'b1;
                dec_next.rd_we     = 1'b1;
            end
            default: begin
                dec_next.supported = 1'b0;
            end
        endcase
        // x0 is never written
        if (dec_next.rd == '0) begin
            dec_next.rd_we = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else if (decode_en) begin
            dec <= dec_next;
        end
    end

endmodule

// ==== design/fetch_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Fetch unit
// PC register, instruction memory request and instruction capture
//////////////////////////////////////////////////////////////////////

module fetch_unit #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            fetch_req,
    input  logic            capture,
    input  logic            execute_en,
    input  core_pkg::word_t imem_rdata,
    input  core_pkg::word_t next_pc,
    output logic            imem_req,
    output core_pkg::word_t imem_addr,
    output core_pkg::word_t pc,
    output core_pkg::word_t instr
);
    import core_pkg::*;

    word_t instr_q;

    // PC and request strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= RESET_PC;
            imem_req <= 1'b0;
        end else begin
            imem_req <= fetch_req;
            if (execute_en) begin
                pc <= next_pc;
            end
        end
    end

    // Request address and fetched word
    always_ff @(posedge clk) begin
        if (fetch_req) begin
            imem_addr <= pc;
        end
        if (capture) begin
            instr_q <= imem_rdata;
        end
    end

    // Word goes straight to decode in the cycle it arrives
    assign instr = capture ? imem_rdata : instr_q;

endmodule

// ==== design/core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Mini core shared types
// Words, opcode and state enums, decoded and retire records
//////////////////////////////////////////////////////////////////////

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // PC step between sequential instructions
    localparam word_t INSTR_BYTES = 32'd4;

    //////////////////////////////////////////////////////////////////////
    // Encodings

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_JAL
    } br_op_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_WAIT_MEM,
        ST_DECODE,
        ST_EXECUTE
    } core_state_e;

    //////////////////////////////////////////////////////////////////////
    // Records

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rd_we;
        logic      use_imm;
        word_t     imm;
        alu_op_e   alu_op;
        br_op_e    br_op;
        // Low for any opcode or function the core does not implement
        logic      supported;
    } decoded_t;

    typedef struct packed {
        word_t     pc;
        word_t     instr;
        reg_addr_t rd;
        logic      rd_we;
        word_t     rd_data;
        word_t     next_pc;
    } retire_t;

endpackage
